//--- rtl/axil_bridge_config.svh
// ==============================
// Widths and depth for the AXI4-Lite bridge
// Data width must be a multiple of 8, depth a power of two
// ==============================
`ifndef AXIL_BRIDGE_CONFIG_SVH
`define AXIL_BRIDGE_CONFIG_SVH

// Byte address width on every AXI channel
`define AXIL_ADDR_W 16

// Data width of W and R beats
`define AXIL_DATA_W 32

// Target memory depth in words
// Mapped bytes run from 0 to AXIL_MEM_WORDS*4-1
`define AXIL_MEM_WORDS 256

`endif

//--- rtl/axil_bridge_pkg.sv
// ==============================
// Shared bridge types, widths from the config header
// ==============================
`include "axil_bridge_config.svh"

package axil_bridge_pkg;

    localparam int unsigned STRB_W = `AXIL_DATA_W / 8;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } axil_op_e;

    // Only the responses this target can produce
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axil_resp_e;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP,
        REPLY
    } mst_state_e;

    // Command stream entry
    typedef struct packed {
        axil_op_e                 op;
        logic [`AXIL_ADDR_W-1:0]  addr;
        logic [`AXIL_DATA_W-1:0]  data;
        logic [STRB_W-1:0]        strb;
        logic [2:0]               prot;
    } axil_cmd_t;

    // Reply stream entry, data is zero for writes
    typedef struct packed {
        axil_resp_e               resp;
        logic [`AXIL_DATA_W-1:0]  data;
    } axil_rsp_t;

    // Shared by AW and AR
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]  addr;
        logic [2:0]               prot;
    } axil_aw_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0]  data;
        logic [STRB_W-1:0]        strb;
    } axil_w_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0]  data;
        axil_resp_e               resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0]               sel;
        logic [`AXIL_ADDR_W-1:0]  value;
    } axil_cfg_t;

    // Locked window, base and limit both inclusive
    typedef struct packed {
        logic                     lock_en;
        logic [`AXIL_ADDR_W-1:0]  base;
        logic [`AXIL_ADDR_W-1:0]  limit;
    } prot_win_t;

endpackage

//--- rtl/axil_cmd_master.sv
// ==============================
// One transaction in flight, no IDs or bursts
// Reply must be taken before the next command
// ==============================
`timescale 1ns/1ns

module axil_cmd_master (
    input  logic                        clk,
    input  logic                        rst_n,

    input  axil_bridge_pkg::axil_cmd_t  cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,

    output axil_bridge_pkg::axil_rsp_t  rsp,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,

    output axil_bridge_pkg::axil_aw_t   aw,
    output logic                        awvalid,
    input  logic                        awready,

    output axil_bridge_pkg::axil_w_t    w,
    output logic                        wvalid,
    input  logic                        wready,

    input  axil_bridge_pkg::axil_resp_e bresp,
    input  logic                        bvalid,
    output logic                        bready,

    output axil_bridge_pkg::axil_aw_t   ar,
    output logic                        arvalid,
    input  logic                        arready,

    input  axil_bridge_pkg::axil_r_t    r,
    input  logic                        rvalid,
    output logic                        rready
);

    axil_bridge_pkg::mst_state_e state;
    axil_bridge_pkg::axil_cmd_t  cmd_q;
    axil_bridge_pkg::axil_rsp_t  rsp_q;

    logic is_write;
    logic aw_done;
    logic w_done;
    logic ar_done;
    logic b_take;
    logic r_take;

    assign is_write = (cmd_q.op == axil_bridge_pkg::OP_WRITE);

    // Channel payloads come straight from the latched command
    assign aw = '{addr: cmd_q.addr, prot: cmd_q.prot};
    assign ar = '{addr: cmd_q.addr, prot: cmd_q.prot};
    assign w  = '{data: cmd_q.data, strb: cmd_q.strb};

    assign bready = (state == axil_bridge_pkg::RESP);
    assign rready = (state == axil_bridge_pkg::RESP);

    // A channel is done once its valid is gone or leaves this cycle
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;
    assign ar_done = !arvalid || arready;

    assign b_take = is_write && bvalid && bready;
    assign r_take = !is_write && rvalid && rready;

    assign rsp = rsp_q;

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (b_take) begin
            rsp_q <= '{resp: bresp, data: '0};
        end else if (r_take) begin
            rsp_q <= '{resp: r.resp, data: r.data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= axil_bridge_pkg::IDLE;
            cmd_ready <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                axil_bridge_pkg::IDLE: begin
                    cmd_ready <= 1'b1;
                    if (cmd_valid && cmd_ready) begin
                        cmd_ready <= 1'b0;
                        awvalid   <= (cmd.op == axil_bridge_pkg::OP_WRITE);
                        wvalid    <= (cmd.op == axil_bridge_pkg::OP_WRITE);
                        arvalid   <= (cmd.op == axil_bridge_pkg::OP_READ);
                        state     <= axil_bridge_pkg::ADDR;
                    end
                end
                axil_bridge_pkg::ADDR: begin
                    // AW and W may complete in either order
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (aw_done && w_done && ar_done) begin
                        state <= axil_bridge_pkg::RESP;
                    end
                end
                axil_bridge_pkg::RESP: begin
                    if (b_take || r_take) begin
                        rsp_valid <= 1'b1;
                        state     <= axil_bridge_pkg::REPLY;
                    end
                end
                axil_bridge_pkg::REPLY: begin
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        cmd_ready <= 1'b1;
                        state     <= axil_bridge_pkg::IDLE;
                    end
                end
                default: state <= axil_bridge_pkg::IDLE;
            endcase
        end
    end

    // AW must not be withdrawn before the target accepts it
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw));

    a_cmd_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ready |-> state == axil_bridge_pkg::IDLE);

endmodule

//--- rtl/axil_mem_target.sv
// ==============================
// Single word per beat, low address bits ignored
// Decode and lock errors leave memory untouched
// ==============================
`timescale 1ns/1ns
`include "axil_bridge_config.svh"

module axil_mem_target (
    input  logic                        clk,
    input  logic                        rst_n,

    input  axil_bridge_pkg::axil_aw_t   aw,
    input  logic                        awvalid,
    output logic                        awready,

    input  axil_bridge_pkg::axil_w_t    w,
    input  logic                        wvalid,
    output logic                        wready,

    output axil_bridge_pkg::axil_resp_e bresp,
    output logic                        bvalid,
    input  logic                        bready,

    input  axil_bridge_pkg::axil_aw_t   ar,
    input  logic                        arvalid,
    output logic                        arready,

    output axil_bridge_pkg::axil_r_t    r,
    output logic                        rvalid,
    input  logic                        rready,

    input  axil_bridge_pkg::prot_win_t  win
);

    localparam int unsigned IDX_W     = $clog2(`AXIL_MEM_WORDS);
    localparam int unsigned MEM_BYTES = `AXIL_MEM_WORDS * 4;

    logic [`AXIL_DATA_W-1:0] mem [`AXIL_MEM_WORDS];

    axil_bridge_pkg::axil_aw_t   aw_q;
    axil_bridge_pkg::axil_w_t    w_q;
    axil_bridge_pkg::axil_resp_e wr_resp;
    axil_bridge_pkg::axil_resp_e rd_resp;

    logic             aw_held;
    logic             w_held;
    logic             wr_commit;
    logic             rd_accept;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    function automatic axil_bridge_pkg::axil_resp_e check_access(
        input logic [`AXIL_ADDR_W-1:0] addr,
        input logic [2:0]              prot,
        input axil_bridge_pkg::prot_win_t win_in
    );
        logic [`AXIL_ADDR_W-1:0] word_addr;
        word_addr = {addr[`AXIL_ADDR_W-1:2], 2'b00};
        if (word_addr >= MEM_BYTES) begin
            return axil_bridge_pkg::RESP_DECERR;
        end
        // prot[0] set means privileged
        if (win_in.lock_en && !prot[0] &&
            word_addr >= win_in.base && word_addr <= win_in.limit) begin
            return axil_bridge_pkg::RESP_SLVERR;
        end
        return axil_bridge_pkg::RESP_OKAY;
    endfunction

    // No new write beats while one is held or B is outstanding
    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;

    assign wr_commit = aw_held && w_held;
    assign rd_accept = arvalid && arready;

    assign wr_idx  = aw_q.addr[IDX_W+1:2];
    assign rd_idx  = ar.addr[IDX_W+1:2];
    assign wr_resp = check_access(aw_q.addr, aw_q.prot, win);
    assign rd_resp = check_access(ar.addr, ar.prot, win);

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_q <= aw;
        end
        if (wvalid && wready) begin
            w_q <= w;
        end
        if (wr_commit) begin
            bresp <= wr_resp;
        end
        if (rd_accept) begin
            r.resp <= rd_resp;
            r.data <= (rd_resp == axil_bridge_pkg::RESP_OKAY) ? mem[rd_idx] : '0;
        end
    end

    // Byte merge under strobe, only for accepted writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AXIL_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_commit && wr_resp == axil_bridge_pkg::RESP_OKAY) begin
            for (int b = 0; b < axil_bridge_pkg::STRB_W; b++) begin
                if (w_q.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= w_q.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (wr_commit) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (awvalid && awready) begin
                    aw_held <= 1'b1;
                end
                if (wvalid && wready) begin
                    w_held <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(r));

endmodule

//--- rtl/axil_prot_regs.sv
// ==============================
// Write-only config, select 3 is ignored
// ==============================
`timescale 1ns/1ns

module axil_prot_regs (
    input  logic                       clk,
    input  logic                       rst_n,

    input  axil_bridge_pkg::axil_cfg_t cfg,
    input  logic                       cfg_valid,
    output logic                       cfg_ready,

    output axil_bridge_pkg::prot_win_t win
);

    localparam logic [1:0] SEL_BASE    = 2'd0;
    localparam logic [1:0] SEL_LIMIT   = 2'd1;
    localparam logic [1:0] SEL_LOCK_EN = 2'd2;

    logic cfg_write;

    assign cfg_write = cfg_valid && cfg_ready;

    // Ready comes up one cycle after reset and stays up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ready <= 1'b0;
        end else begin
            cfg_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win <= '0;
        end else if (cfg_write) begin
            case (cfg.sel)
                SEL_BASE: begin
                    win.base <= cfg.value;
                end
                SEL_LIMIT: begin
                    win.limit <= cfg.value;
                end
                SEL_LOCK_EN: begin
                    win.lock_en <= cfg.value[0];
                end
                default: begin
                    // Unused select, nothing changes
                end
            endcase
        end
    end

endmodule

//--- rtl/axil_bridge_top.sv
// ==============================
// Master, memory target and window registers
// ==============================
`timescale 1ns/1ns

module axil_bridge_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  axil_bridge_pkg::axil_cmd_t  cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,

    output axil_bridge_pkg::axil_rsp_t  rsp,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,

    input  axil_bridge_pkg::axil_cfg_t  cfg,
    input  logic                        cfg_valid,
    output logic                        cfg_ready
);

    // Internal AXI4-Lite channels
    axil_bridge_pkg::axil_aw_t   aw;
    axil_bridge_pkg::axil_aw_t   ar;
    axil_bridge_pkg::axil_w_t    w;
    axil_bridge_pkg::axil_resp_e bresp;
    axil_bridge_pkg::axil_r_t    r;
    axil_bridge_pkg::prot_win_t  win;

    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;

    axil_cmd_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    axil_mem_target u_target (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .win       (win)
    );

    axil_prot_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .win       (win)
    );

endmodule

//--- tests/axil_bridge_tb.sv
// ==============================
// Runs the golden file from the project root
// One command in flight, reply stalls are random
// ==============================
`timescale 1ns/1ns

module axil_bridge_tb;

    // One golden file line, either a config write or a transaction
    typedef struct packed {
        logic                       is_cfg;
        logic [15:0]                num;
        axil_bridge_pkg::axil_cfg_t cfg;
        axil_bridge_pkg::axil_cmd_t cmd;
        logic [1:0]                 exp_resp;
        logic [31:0]                exp_data;
    } test_rec_t;

    logic                       clk;
    logic                       rst_n;
    axil_bridge_pkg::axil_cmd_t cmd;
    logic                       cmd_valid;
    logic                       cmd_ready;
    axil_bridge_pkg::axil_rsp_t rsp;
    logic                       rsp_valid;
    logic                       rsp_ready;
    axil_bridge_pkg::axil_cfg_t cfg;
    logic                       cfg_valid;
    logic                       cfg_ready;

    test_rec_t tests[$];
    bit        loaded;
    int        pass_cnt;
    int        fail_cnt;

    axil_bridge_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_golden(output bit ok);
        int          fd;
        int          code;
        int          ch;
        int          num;
        logic [7:0]  kind;
        logic [31:0] v [7];
        test_rec_t   rec;
        ok = 1'b1;
        fd = $fopen("tests/axil_bridge_golden.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (ok && $fscanf(fd, "%s", kind) == 1) begin
                rec = '0;
                if (kind == "#") begin
                    // Comment line, skip to its end
                    ch = 0;
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (kind == "C") begin
                    code = $fscanf(fd, "%d %h %h", num, v[0], v[1]);
                    rec.is_cfg    = 1'b1;
                    rec.num       = num[15:0];
                    rec.cfg.sel   = v[0][1:0];
                    rec.cfg.value = v[1][15:0];
                    ok = (code == 3);
                    tests.push_back(rec);
                end else if (kind == "T") begin
                    code = $fscanf(fd, "%d %h %h %h %h %h %h %h", num,
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    rec.num      = num[15:0];
                    rec.cmd.op   = axil_bridge_pkg::axil_op_e'(v[0][0]);
                    rec.cmd.addr = v[1][15:0];
                    rec.cmd.data = v[2];
                    rec.cmd.strb = v[3][3:0];
                    rec.cmd.prot = v[4][2:0];
                    rec.exp_resp = v[5][1:0];
                    rec.exp_data = v[6];
                    ok = (code == 8);
                    tests.push_back(rec);
                end else begin
                    $display("Unknown line kind in the golden file");
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic log_result(input test_rec_t t, input int errs);
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        if (t.is_cfg) begin
            $display("Test %0d cfg sel %0d value 0x%h: %s", t.num, t.cfg.sel,
                     t.cfg.value, (errs == 0) ? "PASS" : "FAIL");
        end else begin
            $display("Test %0d %s addr 0x%h prot %0d: %s", t.num,
                     (t.cmd.op == axil_bridge_pkg::OP_WRITE) ? "write" : "read",
                     t.cmd.addr, t.cmd.prot, (errs == 0) ? "PASS" : "FAIL");
        end
    endtask

    task automatic apply_cfg(input test_rec_t t);
        int errs;
        errs = 0;
        @(negedge clk);
        cfg       = t.cfg;
        cfg_valid = 1'b1;
        // Register block takes a write on every cycle after reset
        assert (cfg_ready) else begin
            $display("cfg_ready was low for a config write in test %0d", t.num);
            errs++;
        end
        @(negedge clk);
        cfg_valid = 1'b0;
        log_result(t, errs);
    endtask

    task automatic run_txn(input test_rec_t t);
        axil_bridge_pkg::axil_rsp_t got;
        int stall;
        int errs;
        errs = 0;
        @(negedge clk);
        cmd       = t.cmd;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        while (!rsp_valid) begin
            @(negedge clk);
        end
        got   = rsp;
        stall = $urandom % 4;
        // Master must not take a new command while its reply waits
        assert (!cmd_ready) else begin
            $display("cmd_ready was high with a reply pending in test %0d", t.num);
            errs++;
        end
        // Reply must hold while the stream is stalled
        repeat (stall) begin
            @(negedge clk);
            assert (rsp_valid && rsp == got) else begin
                $display("Reply changed while rsp_ready was low in test %0d", t.num);
                errs++;
            end
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        assert (got.resp == t.exp_resp) else begin
            $display("Mismatch in test %0d: rsp.resp expected 0x%h got 0x%h",
                     t.num, t.exp_resp, got.resp);
            errs++;
        end
        assert (got.data == t.exp_data) else begin
            $display("Mismatch in test %0d: rsp.data expected 0x%h got 0x%h",
                     t.num, t.exp_data, got.data);
            errs++;
        end
        log_result(t, errs);
    endtask

    // Watchdog scaled to the number of golden lines
    initial begin
        wait (loaded);
        repeat (tests.size() * 40 + 200) @(posedge clk);
        $display("Timeout: the tests did not finish in %0d cycles",
                 tests.size() * 40 + 200);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        bit ok;
        void'($urandom(33044));
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        rsp_ready = 1'b0;
        cfg       = '0;
        cfg_valid = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        load_golden(ok);
        loaded = 1'b1;
        if (!ok) begin
            $display("The golden file could not be opened or parsed");
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (16) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            foreach (tests[i]) begin
                if (tests[i].is_cfg) begin
                    apply_cfg(tests[i]);
                end else begin
                    run_txn(tests[i]);
                end
            end
            $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- tests/axil_bridge_golden.txt
# C num sel value                                       (num decimal, rest hex)
# T num op addr data strb prot exp_resp exp_data        (op 1 write, 0 read)
T 1 1 0010 DEADBEEF F 0 0 00000000
T 2 0 0010 00000000 0 0 0 DEADBEEF
T 3 1 0020 11223344 F 0 0 00000000
T 4 1 0020 AABBCCDD 5 0 0 00000000
T 5 1 0020 0000EE00 2 0 0 00000000
T 6 0 0020 00000000 0 0 0 11BBEEDD
T 7 1 03FC CAFEF00D F 0 0 00000000
T 8 0 03FC 00000000 0 0 0 CAFEF00D
T 9 1 0400 12345678 F 0 3 00000000
T 10 0 0400 00000000 0 0 3 00000000
T 11 0 8000 00000000 0 1 3 00000000
T 12 1 0100 A5A5A5A5 F 0 0 00000000
T 13 1 0104 5A5A5A5A F 0 0 00000000
C 14 0 0100
C 15 1 0104
C 16 2 0001
T 17 1 0100 FFFFFFFF F 0 2 00000000
T 18 0 0100 00000000 0 1 0 A5A5A5A5
T 19 0 0104 00000000 0 0 2 00000000
T 20 1 0104 77660000 C 1 0 00000000
T 21 0 0104 00000000 0 1 0 77665A5A
T 22 1 00FC 0BADF00D F 0 0 00000000
T 23 1 0108 600DCAFE F 2 0 00000000
T 24 0 0108 00000000 0 0 0 600DCAFE
C 25 3 FFFF
T 26 0 0100 00000000 0 0 2 00000000
C 27 2 0000
T 28 1 0100 01020304 F 0 0 00000000
T 29 0 0100 00000000 0 0 0 01020304
T 30 0 0013 00000000 0 0 0 DEADBEEF
T 31 0 00FC 00000000 0 0 0 0BADF00D

//--- compile.f
+incdir+rtl
rtl/axil_bridge_pkg.sv
rtl/axil_cmd_master.sv
rtl/axil_mem_target.sv
rtl/axil_prot_regs.sv
rtl/axil_bridge_top.sv
tests/axil_bridge_tb.sv
